//--- hw/accel_consts.svh
/* accelerator constants
   matrix geometry and memory bus widths shared by packages and RTL */
`ifndef ACCEL_CONSTS_SVH
`define ACCEL_CONSTS_SVH

// square matrix side
`define MM_DIM 4
// signed operand element
`define ELEM_W 8
// memory word, also one result element
`define WORD_W 32
// word address
`define MEM_AW 10

`endif

//--- hw/accel_top.sv
/* matrix multiply accelerator
   DMA sequencer, multiply engine and memory arbiter on one external
   word-addressed memory port */
module accel_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  mem_bus_pkg::mem_addr_t a_base_i,
    input  mem_bus_pkg::mem_addr_t b_base_i,
    input  mem_bus_pkg::mem_addr_t c_base_i,
    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output mem_bus_pkg::mem_addr_t mem_addr_o,
    output mem_bus_pkg::mem_word_t mem_wdata_o,
    input  logic                   mem_ready_i,
    input  logic                   mem_rvalid_i,
    input  mem_bus_pkg::mem_word_t mem_rdata_i,
    output logic                   busy_o,
    output logic                   done_o
);
    import mm_pkg::*;

    // loader on port 0, storer on port 1
    mem_if load_if ();
    mem_if store_if ();

    op_matrix_t  mat_a;
    op_matrix_t  mat_b;
    res_matrix_t mat_c;
    logic        mm_start;
    logic        mm_done;

    dma_engine dma_i (
        .clk (clk), .rst_n (rst_n), .start_i (start_i),
        .a_base_i (a_base_i), .b_base_i (b_base_i), .c_base_i (c_base_i),
        .load_mem (load_if.requester), .store_mem (store_if.requester),
        .mat_a_o (mat_a), .mat_b_o (mat_b), .mat_c_i (mat_c),
        .mm_start_o (mm_start), .mm_done_i (mm_done),
        .busy_o (busy_o), .done_o (done_o)
    );

    mm_engine mm_i (
        .clk (clk), .rst_n (rst_n), .start_i (mm_start),
        .mat_a_i (mat_a), .mat_b_i (mat_b), .mat_c_o (mat_c), .done_o (mm_done)
    );

    mem_arbiter arb_i (
        .clk (clk), .rst_n (rst_n),
        .req0_if (load_if.arbiter), .req1_if (store_if.arbiter),
        .mem_req_o (mem_req_o), .mem_we_o (mem_we_o),
        .mem_addr_o (mem_addr_o), .mem_wdata_o (mem_wdata_o),
        .mem_ready_i (mem_ready_i), .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

//--- hw/dma_engine.sv
/* dma engine
   run sequencer: load A and B, start the multiply, wait for it,
   store C and pulse done */
module dma_engine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  mem_bus_pkg::mem_addr_t a_base_i,
    input  mem_bus_pkg::mem_addr_t b_base_i,
    input  mem_bus_pkg::mem_addr_t c_base_i,
    mem_if.requester               load_mem,
    mem_if.requester               store_mem,
    output mm_pkg::op_matrix_t     mat_a_o,
    output mm_pkg::op_matrix_t     mat_b_o,
    input  mm_pkg::res_matrix_t    mat_c_i,
    output logic                   mm_start_o,
    input  logic                   mm_done_i,
    output logic                   busy_o,
    output logic                   done_o
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_COMPUTE,
        ST_STORE
    } state_t;

    state_t state;
    state_t state_n;
    logic   load_start;
    logic   load_done;
    logic   store_start;
    logic   store_done;

    // one-cycle pulses, each on its state transition
    assign load_start  = (state == ST_IDLE) && start_i;
    assign mm_start_o  = (state == ST_LOAD) && load_done;
    assign store_start = (state == ST_COMPUTE) && mm_done_i;
    assign done_o      = (state == ST_STORE) && store_done;
    assign busy_o      = (state != ST_IDLE);

    always_comb begin
        state_n = state;
        case (state)
            ST_IDLE:    if (load_start) state_n = ST_LOAD;
            ST_LOAD:    if (load_done) state_n = ST_COMPUTE;
            ST_COMPUTE: if (mm_done_i) state_n = ST_STORE;
            ST_STORE:   if (store_done) state_n = ST_IDLE;
            default:    state_n = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= state_n;
    end

    dma_loader loader_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (load_start),
        .a_base_i (a_base_i),
        .b_base_i (b_base_i),
        .mem      (load_mem),
        .mat_a_o  (mat_a_o),
        .mat_b_o  (mat_b_o),
        .done_o   (load_done)
    );

    dma_storer storer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (store_start),
        .c_base_i (c_base_i),
        .mat_c_i  (mat_c_i),
        .mem      (store_mem),
        .done_o   (store_done)
    );

    // the multiply engine only finishes a run this sequencer started
    a_mm_done_in_compute: assert property (@(posedge clk) disable iff (!rst_n)
        mm_done_i |-> state == ST_COMPUTE);

endmodule

//--- hw/dma_loader.sv
/* dma loader
   issues the row reads of A then B back to back and collects the in-order
   responses into the operand matrices, both loads in flight together */
`include "accel_consts.svh"

module dma_loader (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  mem_bus_pkg::mem_addr_t a_base_i,
    input  mem_bus_pkg::mem_addr_t b_base_i,
    mem_if.requester               mem,
    output mm_pkg::op_matrix_t     mat_a_o,
    output mm_pkg::op_matrix_t     mat_b_o,
    output logic                   done_o
);
    import mm_pkg::*;
    import mem_bus_pkg::*;

    localparam int ROW_W = $clog2(`MM_DIM);

    // top bit picks the matrix, low bits the row
    logic [ROW_W:0] issue_cnt;
    logic [ROW_W:0] resp_cnt;
    logic           issuing;
    logic           loading;
    mem_addr_t      row_base;
    logic [ROW_W+1:0] accepted;

    assign row_base  = issue_cnt[ROW_W] ? b_base_i : a_base_i;
    assign mem.req   = issuing;
    assign mem.we    = 1'b0;
    assign mem.addr  = row_base + mem_addr_t'(issue_cnt[ROW_W-1:0]);
    assign mem.wdata = '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issuing   <= 1'b0;
            loading   <= 1'b0;
            issue_cnt <= '0;
            resp_cnt  <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i && !loading) begin
                issuing   <= 1'b1;
                loading   <= 1'b1;
                issue_cnt <= '0;
                resp_cnt  <= '0;
            end else begin
                // step on every accepted read, stop after the last B row
                if (issuing && mem.ready) begin
                    issue_cnt <= issue_cnt + 1'b1;
                    if (issue_cnt == '1)
                        issuing <= 1'b0;
                end
                if (loading && mem.rvalid) begin
                    resp_cnt <= resp_cnt + 1'b1;
                    if (resp_cnt == '1) begin
                        loading <= 1'b0;
                        done_o  <= 1'b1;
                    end
                end
            end
        end
    end

    // operand rows, first half of the responses is A
    always_ff @(posedge clk) begin
        if (loading && mem.rvalid) begin
            if (resp_cnt[ROW_W])
                mat_b_o[resp_cnt[ROW_W-1:0]] <= row_t'(mem.rdata);
            else
                mat_a_o[resp_cnt[ROW_W-1:0]] <= row_t'(mem.rdata);
        end
    end

    // reads accepted so far in this run
    assign accepted = issuing ? {1'b0, issue_cnt} : (loading ? (ROW_W+2)'(2 * `MM_DIM) : '0);

    a_resp_le_req: assert property (@(posedge clk) disable iff (!rst_n)
        mem.rvalid |-> loading && ({1'b0, resp_cnt} < accepted));

endmodule

//--- hw/dma_storer.sv
/* dma storer
   writes the result matrix to memory row-major, one word per element,
   word i at c_base + i */
`include "accel_consts.svh"

module dma_storer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  mem_bus_pkg::mem_addr_t c_base_i,
    input  mm_pkg::res_matrix_t    mat_c_i,
    mem_if.requester               mem,
    output logic                   done_o
);
    import mem_bus_pkg::*;

    localparam int ROW_W = $clog2(`MM_DIM);
    localparam int IDX_W = 2 * ROW_W;

    // i = row * dim + col
    logic [IDX_W-1:0] idx;
    logic             active;

    assign mem.req   = active;
    assign mem.we    = active;
    assign mem.addr  = c_base_i + mem_addr_t'(idx);
    assign mem.wdata = mem_word_t'(mat_c_i[idx[IDX_W-1:ROW_W]][idx[ROW_W-1:0]]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            idx    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i && !active) begin
                active <= 1'b1;
                idx    <= '0;
            end else if (active && mem.ready) begin
                // next element only after the handshake
                idx <= idx + 1'b1;
                if (idx == '1) begin
                    active <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    // writes only, and a stalled write keeps address and data
    a_write_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem.req && !mem.ready |=> mem.req && mem.we && $stable(mem.addr)
                                  && $stable(mem.wdata));

endmodule

//--- hw/mem_arbiter.sv
/* memory arbiter
   fixed priority merge of loader (port 0) and storer (port 1) onto the
   external memory port with the grant held until the request is accepted */
module mem_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    mem_if.arbiter                 req0_if,
    mem_if.arbiter                 req1_if,
    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output mem_bus_pkg::mem_addr_t mem_addr_o,
    output mem_bus_pkg::mem_word_t mem_wdata_o,
    input  logic                   mem_ready_i,
    input  logic                   mem_rvalid_i,
    input  mem_bus_pkg::mem_word_t mem_rdata_i
);
    // lock_sel names the owner of a stalled request
    logic locked;
    logic lock_sel;
    logic gnt0;
    logic gnt1;

    // port 0 wins a fresh choice while a stalled owner keeps the bus
    assign gnt0 = locked ? !lock_sel : req0_if.req;
    assign gnt1 = locked ? lock_sel : (!req0_if.req && req1_if.req);

    assign mem_req_o   = (gnt0 && req0_if.req) || (gnt1 && req1_if.req);
    assign mem_we_o    = gnt1 ? req1_if.we : req0_if.we;
    assign mem_addr_o  = gnt1 ? req1_if.addr : req0_if.addr;
    assign mem_wdata_o = gnt1 ? req1_if.wdata : req0_if.wdata;

    // ready only to the owner
    assign req0_if.ready = gnt0 && mem_ready_i;
    assign req1_if.ready = gnt1 && mem_ready_i;

    // only the loader reads
    assign req0_if.rvalid = mem_rvalid_i;
    assign req0_if.rdata  = mem_rdata_i;
    assign req1_if.rvalid = 1'b0;
    assign req1_if.rdata  = '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            locked   <= 1'b0;
            lock_sel <= 1'b0;
        end else begin
            // lock while a granted request waits for ready
            locked   <= mem_req_o && !mem_ready_i;
            lock_sel <= gnt1;
        end
    end

    // a stalled request on the external port stays put
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_o && !mem_ready_i |=> mem_req_o && $stable(mem_addr_o)
                                      && $stable(mem_we_o));

endmodule

//--- hw/mem_bus_pkg.sv
/* mem_bus_pkg
   address and data word types of the word-addressed memory port */
`include "accel_consts.svh"

package mem_bus_pkg;

    // word address, not a byte address
    typedef logic [`MEM_AW-1:0] mem_addr_t;

    // one data word, holds a full matrix row
    // or a single result element
    typedef logic [`WORD_W-1:0] mem_word_t;

endpackage

//--- hw/mem_if.sv
/* mem_if
   valid/ready request bundle with in-order read responses,
   one per requester on the arbiter */
interface mem_if;
    import mem_bus_pkg::*;

    // request side, held until ready
    logic      req;
    logic      we;
    mem_addr_t addr;
    mem_word_t wdata;
    // acceptance and read return
    logic      ready;
    logic      rvalid;
    mem_word_t rdata;

    modport requester (output req, we, addr, wdata,
                       input  ready, rvalid, rdata);

    modport arbiter   (input  req, we, addr, wdata,
                       output ready, rvalid, rdata);

endinterface

//--- hw/mm_engine.sv
/* multiply engine
   4x4 array of accumulators forming C = A*B over four k-steps,
   done a fixed five cycles after start */
`include "accel_consts.svh"

module mm_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  mm_pkg::op_matrix_t  mat_a_i,
    input  mm_pkg::op_matrix_t  mat_b_i,
    output mm_pkg::res_matrix_t mat_c_o,
    output logic                done_o
);
    import mm_pkg::*;

    localparam int ROW_W = $clog2(`MM_DIM);

    res_matrix_t      acc;
    logic [ROW_W-1:0] step;
    logic             running;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
            step    <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                running <= 1'b1;
                step    <= '0;
            end else if (running) begin
                step <= step + 1'b1;
                // last k-step, done lands on the next cycle
                if (step == '1) begin
                    running <= 1'b0;
                    done_o  <= 1'b1;
                end
            end
        end
    end

    // c[r][c] += a[r][k] * b[k][c], operands sign extended first
    always_ff @(posedge clk) begin
        if (start_i) begin
            acc <= '0;
        end else if (running) begin
            for (int r = 0; r < `MM_DIM; r++) begin
                for (int c = 0; c < `MM_DIM; c++) begin
                    acc[r][c] <= acc[r][c]
                        + accum_t'($signed(mat_a_i[r][step]))
                        * accum_t'($signed(mat_b_i[step][c]));
                end
            end
        end
    end

    assign mat_c_o = acc;

endmodule

//--- hw/mm_pkg.sv
/* mm_pkg
   element, row, accumulator and whole-matrix types of the multiply path */
`include "accel_consts.svh"

package mm_pkg;

    // one signed operand element
    typedef logic signed [`ELEM_W-1:0] elem_t;

    // memory image of one row, element 0 in the low byte
    typedef elem_t [`MM_DIM-1:0] row_t;

    // one signed result element
    typedef logic signed [`WORD_W-1:0] accum_t;

    // operand matrix as four rows
    typedef row_t [`MM_DIM-1:0] op_matrix_t;

    // result matrix, first index is the row
    typedef accum_t [`MM_DIM-1:0][`MM_DIM-1:0] res_matrix_t;

endpackage

//--- run.sh
#!/bin/sh
# build the accelerator testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_accel -Mdir "$OBJ" -o tb_accel
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/tb_accel" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi
exit 0

//--- sim.f
+incdir+hw
hw/mem_bus_pkg.sv
hw/mm_pkg.sv
hw/mem_if.sv
hw/mem_arbiter.sv
hw/dma_loader.sv
hw/dma_storer.sv
hw/dma_engine.sv
hw/mm_engine.sv
hw/accel_top.sv
testbench/tb_accel.sv

//--- testbench/tb_accel.sv
/* accelerator testbench
   word memory model with random stalls and read latency, reference
   product and directed runs of the DMA matrix multiply */
`include "accel_consts.svh"

module tb_accel;
    import mm_pkg::*;
    import mem_bus_pkg::*;

    localparam int MEM_WORDS = 1 << `MEM_AW;
    localparam int N_RES     = `MM_DIM * `MM_DIM;
    localparam int RUN_LIMIT = 2000;

    logic      clk;
    logic      rst_n;
    logic      start_i;
    mem_addr_t a_base_i;
    mem_addr_t b_base_i;
    mem_addr_t c_base_i;
    logic      mem_req_o;
    logic      mem_we_o;
    mem_addr_t mem_addr_o;
    mem_word_t mem_wdata_o;
    logic      mem_ready_i  = 1'b1;
    logic      mem_rvalid_i = 1'b0;
    mem_word_t mem_rdata_i  = '0;
    logic      busy_o;
    logic      done_o;

    // memory model state
    mem_word_t mem [MEM_WORDS];
    mem_word_t rd_data_q[$];
    int        rd_due_q[$];
    mem_addr_t wr_addr_q[$];
    int        done_cnt = 0;
    int        cyc = 0;
    logic      stall_en;
    integer    mem_seed;
    integer    stim_seed;

    int          errors;
    int          timeouts;
    op_matrix_t  a_m;
    op_matrix_t  b_m;
    res_matrix_t exp_c;

    accel_top accel_top_i (
        .clk (clk), .rst_n (rst_n), .start_i (start_i),
        .a_base_i (a_base_i), .b_base_i (b_base_i), .c_base_i (c_base_i),
        .mem_req_o (mem_req_o), .mem_we_o (mem_we_o),
        .mem_addr_o (mem_addr_o), .mem_wdata_o (mem_wdata_o),
        .mem_ready_i (mem_ready_i), .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i (mem_rdata_i), .busy_o (busy_o), .done_o (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // memory: accept on req && ready, reads return in order 1 to 3 cycles later
    always @(posedge clk) begin
        integer rnd;
        int     lat;
        if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
            mem_rvalid_i <= 1'b1;
            mem_rdata_i  <= rd_data_q.pop_front();
            void'(rd_due_q.pop_front());
        end else begin
            mem_rvalid_i <= 1'b0;
        end
        if (mem_req_o && mem_ready_i) begin
            if (mem_we_o) begin
                mem[mem_addr_o] = mem_wdata_o;
                wr_addr_q.push_back(mem_addr_o);
            end else begin
                rnd = $random(mem_seed);
                lat = 1 + (rnd & 32'h7fff) % 3;
                rd_data_q.push_back(mem[mem_addr_o]);
                rd_due_q.push_back(cyc + lat);
            end
        end
        if (done_o)
            done_cnt = done_cnt + 1;
        // back-pressure for the next cycle
        rnd = $random(mem_seed);
        mem_ready_i <= stall_en ? rnd[0] : 1'b1;
        cyc = cyc + 1;
    end

    task automatic check_accum(input accum_t got, input accum_t want, input string what);
        if (got !== want) begin
            errors++;
            $display("ERROR %0t: %s got %0d expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_addr(input mem_addr_t got, input mem_addr_t want, input string what);
        if (got !== want) begin
            errors++;
            $display("ERROR %0t: %s got 0x%0h expected 0x%0h", $time, what, got, want);
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            errors++;
            $display("ERROR %0t: %s got %b expected %b", $time, what, got, want);
        end
    endtask

    // C[r][c] = sum over k of A[r][k] * B[k][c], signed
    function automatic res_matrix_t reference_product(input op_matrix_t a, input op_matrix_t b);
        res_matrix_t res;
        int          sum;
        for (int r = 0; r < `MM_DIM; r++) begin
            for (int c = 0; c < `MM_DIM; c++) begin
                sum = 0;
                for (int k = 0; k < `MM_DIM; k++)
                    sum += int'(a[r][k]) * int'(b[k][c]);
                res[r][c] = accum_t'(sum);
            end
        end
        return res;
    endfunction

    task automatic random_matrix(output op_matrix_t m);
        for (int r = 0; r < `MM_DIM; r++)
            for (int k = 0; k < `MM_DIM; k++)
                m[r][k] = elem_t'($random(stim_seed));
    endtask

    // every word tagged with its own address
    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = {6'h2b, mem_addr_t'(i), 6'h15, mem_addr_t'(i)};
    endtask

    task automatic wait_busy(input string what);
        int n;
        n = 0;
        @(posedge clk);
        while (!busy_o && n < RUN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!busy_o) begin
            timeouts++;
            $display("timeout: busy_o never rose in %s", what);
        end
    endtask

    task automatic wait_done(input string what);
        int n;
        n = 0;
        @(posedge clk);
        while (!done_o && n < RUN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!done_o) begin
            timeouts++;
            $display("timeout: no done_o pulse within %0d cycles in %s", RUN_LIMIT, what);
        end
    endtask

    // after a run nothing more may move on the port
    task automatic idle_window(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            check_flag(mem_req_o, 1'b0, "no request after done");
            check_flag(done_o, 1'b0, "no second done");
            check_flag(busy_o, 1'b0, "idle after done");
        end
    endtask

    task automatic run_matmul(input mem_addr_t a_base, input mem_addr_t b_base,
                              input mem_addr_t c_base, input logic restart,
                              input string what);
        int done_mark;
        fill_memory();
        for (int r = 0; r < `MM_DIM; r++) begin
            mem[a_base + mem_addr_t'(r)] = mem_word_t'(a_m[r]);
            mem[b_base + mem_addr_t'(r)] = mem_word_t'(b_m[r]);
        end
        exp_c = reference_product(a_m, b_m);
        wr_addr_q.delete();
        done_mark = done_cnt;
        @(posedge clk);
        a_base_i <= a_base;
        b_base_i <= b_base;
        c_base_i <= c_base;
        start_i  <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        if (restart) begin
            // second pulse lands while the run is in flight
            wait_busy(what);
            start_i <= 1'b1;
            @(posedge clk);
            check_flag(busy_o, 1'b1, "busy at second start");
            start_i <= 1'b0;
        end
        wait_done(what);
        idle_window(20);
        check_flag(done_cnt - done_mark == 1, 1'b1, "exactly one done pulse");
        check_flag(wr_addr_q.size() == N_RES, 1'b1, "sixteen writes");
        for (int i = 0; i < wr_addr_q.size() && i < N_RES; i++)
            check_addr(wr_addr_q[i], c_base + mem_addr_t'(i), $sformatf("write %0d addr", i));
        for (int r = 0; r < `MM_DIM; r++) begin
            for (int c = 0; c < `MM_DIM; c++) begin
                check_accum(accum_t'(mem[c_base + mem_addr_t'(r * `MM_DIM + c)]),
                            exp_c[r][c], $sformatf("%s C[%0d][%0d]", what, r, c));
            end
            check_flag(mem[a_base + mem_addr_t'(r)] == mem_word_t'(a_m[r]), 1'b1,
                       "A row untouched");
            check_flag(mem[b_base + mem_addr_t'(r)] == mem_word_t'(b_m[r]), 1'b1,
                       "B row untouched");
        end
    endtask

    task automatic test_reset();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_flag(mem_req_o, 1'b0, "mem_req_o after reset");
        check_flag(mem_we_o, 1'b0, "mem_we_o after reset");
        check_flag(done_o, 1'b0, "done_o after reset");
        check_flag(busy_o, 1'b0, "busy_o after reset");
    endtask

    // identity times B is B, sign extended
    task automatic test_identity();
        for (int r = 0; r < `MM_DIM; r++)
            for (int k = 0; k < `MM_DIM; k++)
                a_m[r][k] = (r == k) ? elem_t'(1) : elem_t'(0);
        random_matrix(b_m);
        stall_en = 1'b0;
        run_matmul(10'h010, 10'h020, 10'h100, 1'b0, "identity");
        for (int r = 0; r < `MM_DIM; r++)
            for (int c = 0; c < `MM_DIM; c++)
                check_accum(accum_t'(mem[10'h100 + r * `MM_DIM + c]),
                            accum_t'(b_m[r][c]), "identity C equals B");
    endtask

    task automatic test_random();
        random_matrix(a_m);
        random_matrix(b_m);
        // corner products of the signed range
        a_m[0][0] = -8'sd128;
        b_m[0][0] = -8'sd128;
        b_m[0][1] = 8'sd127;
        stall_en = 1'b0;
        run_matmul(10'h040, 10'h0c0, 10'h200, 1'b0, "random");
    endtask

    task automatic test_stall();
        random_matrix(a_m);
        random_matrix(b_m);
        stall_en = 1'b1;
        run_matmul(10'h380, 10'h384, 10'h3f0, 1'b0, "stall");
        stall_en = 1'b0;
    endtask

    task automatic test_busy_start();
        random_matrix(a_m);
        random_matrix(b_m);
        stall_en = 1'b1;
        run_matmul(10'h000, 10'h004, 10'h008, 1'b1, "busy start");
        stall_en = 1'b0;
    endtask

    initial begin
        rst_n     = 1'b0;
        start_i   = 1'b0;
        a_base_i  = '0;
        b_base_i  = '0;
        c_base_i  = '0;
        stall_en  = 1'b0;
        mem_seed  = 32'hb2fb;
        stim_seed = 32'hb2fb;
        errors    = 0;
        timeouts  = 0;
        test_reset();
        test_identity();
        test_random();
        test_stall();
        test_busy_start();
        $display("summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
